//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tex_subsystem
FILELIST  ?= tex_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= sim passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- design/stream_arb.sv
`timescale 1ns/1ps

module stream_arb #(
    parameter int NUM   = 4,
    parameter int DATAW = 32
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic [NUM-1:0]            valid_in,
    input  logic [NUM-1:0][DATAW-1:0] data_in,
    output logic [NUM-1:0]            ready_in,

    output logic                      valid_out,
    output logic [DATAW-1:0]          data_out,
    input  logic                      ready_out
);

    localparam int SELW = (NUM > 1) ? $clog2(NUM) : 1;

    logic [SELW-1:0] rr_ptr;
    logic [SELW-1:0] winner;
    logic [NUM-1:0]  grant;
    logic            any_valid;
    logic            can_load;
    logic            fire;

    // First valid input at or after the pointer wins
    always_comb begin
        int idx;
        logic found;
        idx    = 0;
        found  = 1'b0;
        grant  = '0;
        winner = rr_ptr;
        for (int k = 0; k < NUM; k++) begin
            idx = (int'(rr_ptr) + k) % NUM;
            if (!found && valid_in[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                winner     = SELW'(idx);
            end
        end
    end

    assign any_valid = |valid_in;
    assign can_load  = !valid_out || ready_out; // Register empty or draining
    assign fire      = any_valid && can_load;
    assign ready_in  = grant & {NUM{can_load}};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            rr_ptr    <= '0;
        end else if (can_load) begin
            valid_out <= any_valid;
            if (fire) begin
                rr_ptr <= (int'(winner) == NUM - 1) ? '0 : winner + 1'b1; // Start after winner
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            data_out <= data_in[winner];
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        any_valid |-> $onehot(grant));

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

endmodule

//--- design/stream_switch.sv
`timescale 1ns/1ps

module stream_switch #(
    parameter int NUM   = 4,
    parameter int DATAW = 32,
    localparam int SELW = (NUM > 1) ? $clog2(NUM) : 1
) (
    input  logic [SELW-1:0]           sel_in,

    input  logic                      valid_in,
    input  logic [DATAW-1:0]          data_in,
    output logic                      ready_in,

    output logic [NUM-1:0]            valid_out,
    output logic [NUM-1:0][DATAW-1:0] data_out,
    input  logic [NUM-1:0]            ready_out
);

    logic sel_ok;

    assign sel_ok = (int'(sel_in) < NUM); // Guards non power of two counts

    // Only the selected target sees valid
    always_comb begin
        valid_out = '0;
        ready_in  = 1'b0;
        if (sel_ok) begin
            valid_out[sel_in] = valid_in;
            ready_in          = ready_out[sel_in];
        end
        a_valid_onehot0: assert ($onehot0(valid_out))
            else $error("stream_switch drives more than one target");
    end

    // Payload goes to every target
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            data_out[i] = data_in;
        end
    end

endmodule

//--- design/tex_arb.sv
`timescale 1ns/1ps
`include "tex_consts.svh"

module tex_arb import tex_pkg::*; (
    input  logic                               clk,
    input  logic                               reset,

    input  logic [`TEX_NUM_REQS-1:0]           req_valid,
    input  tex_req_t [`TEX_NUM_REQS-1:0]       req,
    output logic [`TEX_NUM_REQS-1:0]           req_ready,

    output logic [`TEX_NUM_REQS-1:0]           rsp_valid,
    output tex_rsp_t [`TEX_NUM_REQS-1:0]       rsp,
    input  logic [`TEX_NUM_REQS-1:0]           rsp_ready,

    output logic                               smp_req_valid,
    output tex_req_t                           smp_req,
    input  logic                               smp_req_ready,

    input  logic                               smp_rsp_valid,
    input  tex_rsp_t                           smp_rsp,
    output logic                               smp_rsp_ready
);

    tex_req_t [`TEX_NUM_REQS-1:0] req_marked;
    tex_rsp_t                     rsp_unmarked;
    logic [TEX_SEL_BITS-1:0]      rsp_sel;

    // Requester index goes in below the requester's own tag
    always_comb begin
        for (int i = 0; i < `TEX_NUM_REQS; i++) begin
            req_marked[i]     = req[i];
            req_marked[i].tag = {req[i].tag[`TEX_TAG_BITS-1:0], TEX_SEL_BITS'(i)};
        end
    end

    stream_arb #(
        .NUM   (`TEX_NUM_REQS),
        .DATAW ($bits(tex_req_t))
    ) u_req_arb (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid),
        .data_in   (req_marked),
        .ready_in  (req_ready),
        .valid_out (smp_req_valid),
        .data_out  (smp_req),
        .ready_out (smp_req_ready)
    );

    assign rsp_sel             = smp_rsp.tag[TEX_SEL_BITS-1:0];
    assign rsp_unmarked.tag    = {{TEX_SEL_BITS{1'b0}}, smp_rsp.tag[TEX_TAG_OUT_BITS-1:TEX_SEL_BITS]};
    assign rsp_unmarked.texels = smp_rsp.texels;

    stream_switch #(
        .NUM   (`TEX_NUM_REQS),
        .DATAW ($bits(tex_rsp_t))
    ) u_rsp_switch (
        .sel_in    (rsp_sel),
        .valid_in  (smp_rsp_valid),
        .data_in   (rsp_unmarked),
        .ready_in  (smp_rsp_ready),
        .valid_out (rsp_valid),
        .data_out  (rsp),
        .ready_out (rsp_ready)
    );

endmodule

//--- design/tex_consts.svh
`ifndef TEX_CONSTS_SVH
`define TEX_CONSTS_SVH

// Sizing of the texture request front end

`define TEX_NUM_LANES      2  // Lanes per request
`define TEX_NUM_REQS       4  // Requester lane groups

`define TEX_TAG_BITS       6  // Requester side tag
`define TEX_LOD_BITS       8  // Per lane level of detail
`define TEX_STAGE_BITS     2  // Texture stage index

`define TEX_SAMPLER_DEPTH  3  // Sampler pipeline stages

`endif

//--- design/tex_pkg.sv
`include "tex_consts.svh"

package tex_pkg;

    // Requester index carried in the low tag bits toward the sampler
    localparam int TEX_SEL_BITS     = (`TEX_NUM_REQS > 1) ? $clog2(`TEX_NUM_REQS) : 1;
    localparam int TEX_TAG_OUT_BITS = `TEX_TAG_BITS + TEX_SEL_BITS;

    typedef struct packed {
        logic [TEX_TAG_OUT_BITS-1:0]                    tag;
        logic [`TEX_NUM_LANES-1:0]                      mask;
        logic [`TEX_NUM_LANES-1:0][31:0]                u;
        logic [`TEX_NUM_LANES-1:0][31:0]                v;
        logic [`TEX_NUM_LANES-1:0][`TEX_LOD_BITS-1:0]   lod;
        logic [`TEX_STAGE_BITS-1:0]                     stage;
    } tex_req_t;

    typedef struct packed {
        logic [TEX_TAG_OUT_BITS-1:0]                    tag;
        logic [`TEX_NUM_LANES-1:0][31:0]                texels;
    } tex_rsp_t;

endpackage

//--- design/tex_sampler.sv
`timescale 1ns/1ps
`include "tex_consts.svh"

module tex_sampler import tex_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      req_valid,
    input  tex_req_t  req,
    output logic      req_ready,

    output logic      rsp_valid,
    output tex_rsp_t  rsp,
    input  logic      rsp_ready
);

    localparam int LOD_PAD = 32 - `TEX_STAGE_BITS - `TEX_LOD_BITS;

    // The stage logic below is written for a fixed depth
    if (`TEX_SAMPLER_DEPTH != 3) begin : g_depth_check
        $error("tex_sampler implements exactly three stages");
    end

    logic                                          stall;
    logic                                          s1_valid;
    logic                                          s2_valid;
    logic                                          s3_valid;
    tex_rsp_t                                      s1_data;
    tex_rsp_t                                      s2_data;
    tex_rsp_t                                      s3_data;
    logic [`TEX_NUM_LANES-1:0]                     s1_mask;
    logic [`TEX_NUM_LANES-1:0]                     s2_mask;
    logic [`TEX_NUM_LANES-1:0][`TEX_LOD_BITS-1:0]  s1_lod;
    logic [`TEX_STAGE_BITS-1:0]                    s1_stage;

    assign stall     = s3_valid && !rsp_ready; // Whole pipe freezes
    assign req_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_data.tag <= req.tag;
            s1_mask     <= req.mask;
            s1_lod      <= req.lod;
            s1_stage    <= req.stage;
            s2_data.tag <= s1_data.tag;
            s2_mask     <= s1_mask;
            s3_data.tag <= s2_data.tag;
            for (int l = 0; l < `TEX_NUM_LANES; l++) begin
                s1_data.texels[l] <= req.u[l] + req.v[l];
                s2_data.texels[l] <= s1_data.texels[l]
                                   ^ {s1_stage, {LOD_PAD{1'b0}}, s1_lod[l]};
                s3_data.texels[l] <= s2_mask[l] ? s2_data.texels[l] : 32'd0; // Masked lanes read zero
            end
        end
    end

    assign rsp_valid = s3_valid;
    assign rsp       = s3_data;

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- design/tex_subsystem.sv
`timescale 1ns/1ps
`include "tex_consts.svh"

module tex_subsystem import tex_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [`TEX_NUM_REQS-1:0]      req_valid,
    input  tex_req_t [`TEX_NUM_REQS-1:0]  req,
    output logic [`TEX_NUM_REQS-1:0]      req_ready,

    output logic [`TEX_NUM_REQS-1:0]      rsp_valid,
    output tex_rsp_t [`TEX_NUM_REQS-1:0]  rsp,
    input  logic [`TEX_NUM_REQS-1:0]      rsp_ready
);

    logic     smp_req_valid;
    tex_req_t smp_req;
    logic     smp_req_ready;
    logic     smp_rsp_valid;
    tex_rsp_t smp_rsp;
    logic     smp_rsp_ready;

    tex_arb u_arb (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .smp_req_valid (smp_req_valid),
        .smp_req       (smp_req),
        .smp_req_ready (smp_req_ready),
        .smp_rsp_valid (smp_rsp_valid),
        .smp_rsp       (smp_rsp),
        .smp_rsp_ready (smp_rsp_ready)
    );

    tex_sampler u_sampler (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smp_req_valid),
        .req       (smp_req),
        .req_ready (smp_req_ready),
        .rsp_valid (smp_rsp_valid),
        .rsp       (smp_rsp),
        .rsp_ready (smp_rsp_ready)
    );

endmodule

//--- sim/tb_tex_subsystem.sv
`timescale 1ns/1ps
`include "tex_consts.svh"

module tb_tex_subsystem import tex_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int NREQ        = `TEX_NUM_REQS;
    localparam int LANES       = `TEX_NUM_LANES;
    localparam int TAG_BITS    = `TEX_TAG_BITS;
    localparam int EXP_LATENCY = `TEX_SAMPLER_DEPTH + 1; // Arbiter register plus sampler stages
    localparam int BURST_N     = 4;
    localparam int RAND_N      = 40;
    localparam int BLOCK_N     = 10;
    localparam int BLOCK_PORT  = 2;
    localparam int WATCHDOG    = NREQ * (1 + BURST_N + RAND_N + BLOCK_N) * 40 + 500;
    localparam int M_DIRECTED  = 0;
    localparam int M_BURST     = 1;
    localparam int M_RANDOM    = 2;
    localparam int M_BLOCK     = 3;

    logic                clk = 1'b0;
    logic                reset;
    logic [NREQ-1:0]     req_valid;
    tex_req_t [NREQ-1:0] req;
    logic [NREQ-1:0]     req_ready;
    logic [NREQ-1:0]     rsp_valid;
    tex_rsp_t [NREQ-1:0] rsp;
    logic [NREQ-1:0]     rsp_ready;

    logic [31:0]         rng_state = 32'd99710;
    int                  mode = M_DIRECTED;
    int                  target [NREQ];
    int                  issued [NREQ];
    logic [NREQ-1:0]     accepted = '0;
    logic [NREQ-1:0]     stalled = '0;
    tex_rsp_t            held_rsp [NREQ];
    tex_rsp_t            exp_q [NREQ][$];
    int                  acc_cyc_q [NREQ][$];
    int                  grant_log [$];
    int                  cycle = 0;
    int                  data_errors = 0;
    int                  flow_errors = 0;

    tex_subsystem u_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Sum of u and v, lod into the low byte, stage into the top bits, masked lanes zero
    function automatic logic [LANES-1:0][31:0] ref_texels(input tex_req_t r);
        logic [LANES-1:0][31:0] t;
        for (int l = 0; l < LANES; l++) begin
            t[l] = r.u[l] + r.v[l];
            t[l][`TEX_LOD_BITS-1:0] = t[l][`TEX_LOD_BITS-1:0] ^ r.lod[l];
            t[l][31:32-`TEX_STAGE_BITS] = t[l][31:32-`TEX_STAGE_BITS] ^ r.stage;
            if (!r.mask[l]) begin
                t[l] = '0;
            end
        end
        return t;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < NREQ; p++) begin
            n += target[p] - issued[p] + int'(req_valid[p]) + exp_q[p].size();
        end
        return n;
    endfunction

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #1;
        end while (pending() != 0);
    endtask

    task automatic add_requests(input int n);
        for (int p = 0; p < NREQ; p++) begin
            target[p] += n;
        end
    endtask

    initial begin
        tex_req_t    r;
        logic [31:0] x;
        logic [31:0] y;
        req_valid = '0;
        req       = '0;
        rsp_ready = '0;
        issued    = '{default: 0};
        forever begin
            @(negedge clk);
            for (int p = 0; p < NREQ; p++) begin
                x = next_rand();
                if (req_valid[p] && accepted[p]) begin
                    req_valid[p] = 1'b0;
                end
                if (!req_valid[p] && issued[p] < target[p] && (mode != M_RANDOM || x[0])) begin
                    r = '0;
                    for (int l = 0; l < LANES; l++) begin
                        r.u[l]   = next_rand();
                        r.v[l]   = next_rand();
                        y        = next_rand();
                        r.lod[l] = y[`TEX_LOD_BITS-1:0];
                    end
                    r.stage = x[8 +: `TEX_STAGE_BITS];
                    r.mask  = (mode == M_DIRECTED) ? LANES'(3 - p) : x[12 +: LANES];
                    r.tag   = {{TEX_SEL_BITS{1'b0}}, TAG_BITS'(issued[p])}; // Running count
                    req[p]       = r;
                    req_valid[p] = 1'b1;
                    issued[p]++;
                end
                rsp_ready[p] = (mode == M_RANDOM) ? (x[2:1] != 2'b00)
                                                  : !(mode == M_BLOCK && p == BLOCK_PORT);
            end
        end
    end

    // Scoreboard, sampled just before the rising edge
    always @(negedge clk) begin
        tex_rsp_t e;
        int       lat;
        #(CLK_PERIOD / 2 - 1);
        cycle++;
        if (!reset) begin
            for (int p = 0; p < NREQ; p++) begin
                if (stalled[p] && !rsp_valid[p]) begin
                    $display("Error: %0t rsp_valid[%0d] expected 1 got 0", $time, p);
                    data_errors++;
                end
                if (stalled[p] && rsp[p] !== held_rsp[p]) begin
                    $display("Error: %0t rsp[%0d] expected %h got %h", $time, p, held_rsp[p], rsp[p]);
                    data_errors++;
                end
                if (rsp_valid[p] && rsp_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Port %0d returned a response at %0t with no request outstanding",
                                 p, $time);
                        data_errors++;
                    end else begin
                        e   = exp_q[p].pop_front();
                        lat = cycle - acc_cyc_q[p].pop_front();
                        if (rsp[p].tag !== e.tag) begin
                            $display("Error: %0t rsp[%0d].tag expected %h got %h",
                                     $time, p, e.tag, rsp[p].tag);
                            data_errors++;
                        end
                        if (rsp[p].texels !== e.texels) begin
                            $display("Error: %0t rsp[%0d].texels expected %h got %h",
                                     $time, p, e.texels, rsp[p].texels);
                            data_errors++;
                        end
                        if (mode == M_DIRECTED && lat != EXP_LATENCY) begin
                            $display("Error: %0t rsp_valid[%0d] latency expected %0d got %0d",
                                     $time, p, EXP_LATENCY, lat);
                            data_errors++;
                        end
                    end
                end
                stalled[p]  = rsp_valid[p] && !rsp_ready[p];
                held_rsp[p] = rsp[p];
                accepted[p] = req_valid[p] && req_ready[p];
                if (accepted[p]) begin
                    e.tag    = {{TEX_SEL_BITS{1'b0}}, req[p].tag[TAG_BITS-1:0]};
                    e.texels = ref_texels(req[p]);
                    exp_q[p].push_back(e);
                    acc_cyc_q[p].push_back(cycle);
                    if (mode == M_BURST) begin
                        grant_log.push_back(p);
                    end
                end
            end
        end
    end

    initial begin
        logic [NREQ-1:0] seen;
        target = '{default: 0};
        reset  = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (rsp_valid !== '0) begin
            $display("Error: %0t rsp_valid expected %b got %b", $time, {NREQ{1'b0}}, rsp_valid);
            flow_errors++;
        end
        wait_idle();
        for (int p = 0; p < NREQ; p++) begin // One port at a time, no contention
            target[p] = 1;
            wait_idle();
        end
        mode = M_BURST;
        add_requests(BURST_N);
        wait_idle();
        for (int g = 0; g < NREQ * BURST_N; g += NREQ) begin
            seen = '0;
            for (int k = 0; k < NREQ && g + k < grant_log.size(); k++) begin
                seen[grant_log[g + k]] = 1'b1;
            end
            if (seen !== '1) begin
                $display("Error: %0t grant set %0d expected %b got %b", $time, g / NREQ, {NREQ{1'b1}},
                         seen);
                flow_errors++;
            end
        end
        mode = M_RANDOM;
        add_requests(RAND_N);
        wait_idle();
        mode = M_BLOCK; // Pipe backs up behind the stuck port
        add_requests(BLOCK_N);
        repeat (30) @(posedge clk);
        #1;
        if (!rsp_valid[BLOCK_PORT]) begin
            $display("Port %0d never presented a response while held not ready", BLOCK_PORT);
            flow_errors++;
        end
        mode = M_RANDOM;
        wait_idle();
        $display("Summary: %0d data errors, %0d flow errors", data_errors, flow_errors);
        if (data_errors + flow_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Timeout: %0d requests or responses still pending after %0d cycles",
                 pending(), WATCHDOG);
        $display("Summary: %0d data errors, %0d flow errors", data_errors, flow_errors);
        $display("sim failed");
        $finish;
    end

endmodule

//--- tex_subsystem.f
+incdir+design
design/tex_pkg.sv
design/stream_arb.sv
design/stream_switch.sv
design/tex_arb.sv
design/tex_sampler.sv
design/tex_subsystem.sv
sim/tb_tex_subsystem.sv
